/* icache_config.svh */
// Cache geometry and address width macros
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Sets and ways
`define ICACHE_SETS 256
`define ICACHE_INDEX_WIDTH 8
`define ICACHE_WAYS 2

// Block and instruction sizes
`define ICACHE_BLOCK_WIDTH 128
`define ICACHE_OFFSET_WIDTH 4
`define ICACHE_INSTR_WIDTH 32

// Address layout, index plus offset spans the page offset
`define ICACHE_VADDR_WIDTH 32
`define ICACHE_PADDR_WIDTH 32
`define ICACHE_PAGE_OFFSET_WIDTH 12
`define ICACHE_PTAG_WIDTH 20

`endif

/* icache_pkg.sv */
// Miss controller state enum and engine tag-write opcode enum
package icache_pkg;

  ////////////////////
  // Miss controller
  ////////////////////

  // Ready for fetches, holding a request, or waiting on the engine
  typedef enum logic [1:0]
  {
    e_ready = 2'd0,
    e_req   = 2'd1,
    e_miss  = 2'd2
  } icache_state_e;

  ////////////////////
  // Engine packets
  ////////////////////

  // Set writes one way and marks it valid
  // Clear drops both ways of the set
  typedef enum logic
  {
    e_tag_set   = 1'b0,
    e_tag_clear = 1'b1
  } icache_tag_op_e;

endpackage

/* icache_tag_array.sv */
// Tag and valid storage per way, engine tag writes and the per-way tag compare
`timescale 1ns/1ns
`include "icache_config.svh"

module icache_tag_array
  (input                                   clk_i
   , input                                 reset_i
   , input                                 read_v_i
   , input [`ICACHE_INDEX_WIDTH-1:0]       read_index_i
   , input [`ICACHE_PTAG_WIDTH-1:0]        ptag_i
   , input                                 tag_pkt_v_i
   , input icache_pkg::icache_tag_op_e     tag_pkt_op_i
   , input [`ICACHE_INDEX_WIDTH-1:0]       tag_pkt_index_i
   , input [$clog2(`ICACHE_WAYS)-1:0]      tag_pkt_way_i
   , input [`ICACHE_PTAG_WIDTH-1:0]        tag_pkt_tag_i
   , output logic                          tag_pkt_yumi_o
   , output logic [`ICACHE_WAYS-1:0]       hit_way_o
   );

  localparam int way_width_lp = $clog2(`ICACHE_WAYS);

  logic                    read_v_r;
  logic [`ICACHE_WAYS-1:0] set_w;
  logic                    clear_w;

  // Fetch reads win, packets wait for a free cycle
  assign tag_pkt_yumi_o = tag_pkt_v_i & ~read_v_i;
  assign clear_w = tag_pkt_yumi_o & (tag_pkt_op_i == icache_pkg::e_tag_clear);

  // Compare only counts in the cycle right after a read
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      read_v_r <= 1'b0;
    else
      read_v_r <= read_v_i;
  end

  for (genvar w = 0; w < `ICACHE_WAYS; w++)
  begin : g_way
    logic [`ICACHE_PTAG_WIDTH-1:0] tag_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]       valid_mem;
    logic [`ICACHE_PTAG_WIDTH-1:0] tag_rd_r;
    logic                          valid_rd_r;

    assign set_w[w] = tag_pkt_yumi_o
                    & (tag_pkt_op_i == icache_pkg::e_tag_set)
                    & (tag_pkt_way_i == way_width_lp'(w));

    always_ff @(posedge clk_i)
    begin
      if (set_w[w])
      begin
        tag_mem[tag_pkt_index_i]   <= tag_pkt_tag_i;
        valid_mem[tag_pkt_index_i] <= 1'b1;
      end
      else if (clear_w)
        valid_mem[tag_pkt_index_i] <= 1'b0;
      if (read_v_i)
      begin
        tag_rd_r   <= tag_mem[read_index_i];
        valid_rd_r <= valid_mem[read_index_i];
      end
    end

    // Physical tag arrives in tag lookup
    assign hit_way_o[w] = read_v_r & valid_rd_r & (tag_rd_r == ptag_i);
  end

  // The engine never installs one tag in both ways of a set
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(hit_way_o));

endmodule

/* icache_data_array.sv */
// Per-way block storage with engine block writes and synchronous fetch reads
`timescale 1ns/1ns
`include "icache_config.svh"

module icache_data_array
  (input                                                      clk_i
   , input                                                    reset_i
   , input                                                    read_v_i
   , input [`ICACHE_INDEX_WIDTH-1:0]                          read_index_i
   , input                                                    data_pkt_v_i
   , input [`ICACHE_INDEX_WIDTH-1:0]                          data_pkt_index_i
   , input [$clog2(`ICACHE_WAYS)-1:0]                         data_pkt_way_i
   , input [`ICACHE_BLOCK_WIDTH-1:0]                          data_pkt_data_i
   , output logic                                             data_pkt_yumi_o
   , output logic [`ICACHE_WAYS-1:0][`ICACHE_BLOCK_WIDTH-1:0] way_data_o
   );

  localparam int way_width_lp = $clog2(`ICACHE_WAYS);

  logic [`ICACHE_WAYS-1:0] way_w;

  // Block writes only in cycles without a fetch
  assign data_pkt_yumi_o = data_pkt_v_i & ~read_v_i;

  for (genvar w = 0; w < `ICACHE_WAYS; w++)
  begin : g_way
    logic [`ICACHE_BLOCK_WIDTH-1:0] block_mem [`ICACHE_SETS];
    logic [`ICACHE_BLOCK_WIDTH-1:0] rd_data_r;

    assign way_w[w] = data_pkt_yumi_o & (data_pkt_way_i == way_width_lp'(w));

    // Output holds the last read until the next fetch
    always_ff @(posedge clk_i)
    begin
      if (way_w[w])
        block_mem[data_pkt_index_i] <= data_pkt_data_i;
      if (read_v_i)
        rd_data_r <= block_mem[read_index_i];
    end

    assign way_data_o[w] = rd_data_r;
  end

  // A refused block write stays offered to the same set and way until taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    (data_pkt_v_i && !data_pkt_yumi_o)
    |=> (data_pkt_v_i && $stable(data_pkt_index_i) && $stable(data_pkt_way_i)));

endmodule

/* icache_lru.sv */
// Per-set LRU bits, hit update and the replacement way metadata register
`timescale 1ns/1ns
`include "icache_config.svh"

module icache_lru
  (input                                   clk_i
   , input                                 reset_i
   , input                                 hit_v_i
   , input [$clog2(`ICACHE_WAYS)-1:0]      hit_way_i
   , input [`ICACHE_INDEX_WIDTH-1:0]       index_i
   , input                                 req_yumi_i
   , output logic                          metadata_v_o
   , output logic [$clog2(`ICACHE_WAYS)-1:0] metadata_way_o
   );

  localparam int way_width_lp = $clog2(`ICACHE_WAYS);

  // Most recently hit way of each set
  logic [way_width_lp-1:0] lru_r [`ICACHE_SETS];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
        lru_r[s] <= '0;
    end
    else if (hit_v_i)
      lru_r[index_i] <= hit_way_i;
  end

  // Metadata trails the engine yumi by one cycle
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      metadata_v_o <= 1'b0;
    else
      metadata_v_o <= req_yumi_i;
  end

  // Two ways, the victim is whichever way was not hit last
  always_ff @(posedge clk_i)
  begin
    if (req_yumi_i)
      metadata_way_o <= ~lru_r[index_i];
  end

endmodule

/* icache_miss_ctrl.sv */
// Ready/req/miss state machine and the cache request handshake
`timescale 1ns/1ns
`include "icache_config.svh"

module icache_miss_ctrl
  (input                                   clk_i
   , input                                 reset_i
   , input                                 miss_i
   , input [`ICACHE_PADDR_WIDTH-1:0]       miss_addr_i
   , input                                 req_yumi_i
   , input                                 complete_i
   , output logic                          ready_o
   , output logic                          req_v_o
   , output logic [`ICACHE_PADDR_WIDTH-1:0] req_addr_o
   );

  icache_pkg::icache_state_e       state_r;
  icache_pkg::icache_state_e       state_n;
  logic [`ICACHE_PADDR_WIDTH-1:0]  addr_r;

  // Request goes out straight from tag verify, then from the held address
  always_comb
  begin
    state_n    = state_r;
    req_v_o    = 1'b0;
    req_addr_o = addr_r;
    case (state_r)
      icache_pkg::e_ready:
      begin
        if (miss_i)
        begin
          req_v_o    = 1'b1;
          req_addr_o = miss_addr_i;
          state_n    = req_yumi_i ? icache_pkg::e_miss : icache_pkg::e_req;
        end
      end
      icache_pkg::e_req:
      begin
        req_v_o = 1'b1;
        if (req_yumi_i)
          state_n = icache_pkg::e_miss;
      end
      icache_pkg::e_miss:
      begin
        // Engine has written block and tag
        if (complete_i)
          state_n = icache_pkg::e_ready;
      end
      default:
        state_n = icache_pkg::e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= icache_pkg::e_ready;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if ((state_r == icache_pkg::e_ready) && miss_i)
      addr_r <= miss_addr_i;
  end

  // No fetches taken while reset is held
  assign ready_o = ~reset_i & (state_r == icache_pkg::e_ready) & ~miss_i;

  // Request held with a stable address until the engine takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    (req_v_o && !req_yumi_i) |=> (req_v_o && $stable(req_addr_o)));

endmodule

/* icache_top.sv */
// Instruction cache top, fetch pipeline registers, word select and sub-block instances
`timescale 1ns/1ns
`include "icache_config.svh"

module icache_top
  (input                                     clk_i
   , input                                   reset_i
   , input                                   fetch_v_i
   , input [`ICACHE_VADDR_WIDTH-1:0]         fetch_vaddr_i
   , output logic                            ready_o
   , input [`ICACHE_PTAG_WIDTH-1:0]          ptag_i
   , input                                   ptag_v_i
   , output logic [`ICACHE_INSTR_WIDTH-1:0]  data_o
   , output logic                            data_v_o
   , output logic                            miss_v_o
   , output logic                            cache_req_v_o
   , output logic [`ICACHE_PADDR_WIDTH-1:0]  cache_req_addr_o
   , input                                   cache_req_yumi_i
   , output logic                            cache_req_metadata_v_o
   , output logic [$clog2(`ICACHE_WAYS)-1:0] cache_req_metadata_way_o
   , input                                   cache_req_complete_i
   , input                                   tag_pkt_v_i
   , input icache_pkg::icache_tag_op_e       tag_pkt_op_i
   , input [`ICACHE_INDEX_WIDTH-1:0]         tag_pkt_index_i
   , input [$clog2(`ICACHE_WAYS)-1:0]        tag_pkt_way_i
   , input [`ICACHE_PTAG_WIDTH-1:0]          tag_pkt_tag_i
   , output logic                            tag_pkt_yumi_o
   , input                                   data_pkt_v_i
   , input [`ICACHE_INDEX_WIDTH-1:0]         data_pkt_index_i
   , input [$clog2(`ICACHE_WAYS)-1:0]        data_pkt_way_i
   , input [`ICACHE_BLOCK_WIDTH-1:0]         data_pkt_data_i
   , output logic                            data_pkt_yumi_o
   );

  localparam int way_width_lp      = $clog2(`ICACHE_WAYS);
  localparam int word_sel_width_lp = `ICACHE_OFFSET_WIDTH - 2;

  logic                                             tl_we;
  logic                                             tv_we;
  logic                                             v_tl_r;
  logic                                             v_tv_r;
  logic [`ICACHE_PAGE_OFFSET_WIDTH-1:0]             vaddr_tl_r;
  logic [`ICACHE_WAYS-1:0]                          hit_way_tl;
  logic [`ICACHE_WAYS-1:0][`ICACHE_BLOCK_WIDTH-1:0] way_data_tl;
  logic [`ICACHE_PADDR_WIDTH-1:0]                   paddr_tv_r;
  logic [`ICACHE_WAYS-1:0]                          hit_tv_r;
  logic [`ICACHE_WAYS-1:0][`ICACHE_BLOCK_WIDTH-1:0] way_data_tv_r;
  logic [way_width_lp-1:0]                          hit_idx_tv;
  logic [`ICACHE_BLOCK_WIDTH-1:0]                   block_tv;
  logic [word_sel_width_lp-1:0]                     word_sel_tv;

  ////////////////////
  // Decode
  ////////////////////
  wire [`ICACHE_INDEX_WIDTH-1:0] fetch_index =
    fetch_vaddr_i[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];

  assign tl_we = ready_o & fetch_v_i;

  icache_tag_array tag_array_i
    (.clk_i(clk_i), .reset_i(reset_i), .read_v_i(tl_we), .read_index_i(fetch_index)
     , .ptag_i(ptag_i), .tag_pkt_v_i(tag_pkt_v_i), .tag_pkt_op_i(tag_pkt_op_i)
     , .tag_pkt_index_i(tag_pkt_index_i), .tag_pkt_way_i(tag_pkt_way_i)
     , .tag_pkt_tag_i(tag_pkt_tag_i), .tag_pkt_yumi_o(tag_pkt_yumi_o)
     , .hit_way_o(hit_way_tl));

  icache_data_array data_array_i
    (.clk_i(clk_i), .reset_i(reset_i), .read_v_i(tl_we), .read_index_i(fetch_index)
     , .data_pkt_v_i(data_pkt_v_i), .data_pkt_index_i(data_pkt_index_i)
     , .data_pkt_way_i(data_pkt_way_i), .data_pkt_data_i(data_pkt_data_i)
     , .data_pkt_yumi_o(data_pkt_yumi_o), .way_data_o(way_data_tl));

  ////////////////////
  // Tag lookup
  ////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_tl_r <= 1'b0;
      v_tv_r <= 1'b0;
    end
    else
    begin
      v_tl_r <= tl_we;
      v_tv_r <= tv_we;
    end
  end

  // Only the page offset is needed once the physical tag arrives
  always_ff @(posedge clk_i)
  begin
    if (tl_we)
      vaddr_tl_r <= fetch_vaddr_i[`ICACHE_PAGE_OFFSET_WIDTH-1:0];
  end

  // A miss in tag verify squashes the fetch behind it
  assign tv_we = v_tl_r & ptag_v_i & ~miss_v_o;

  always_ff @(posedge clk_i)
  begin
    if (tv_we)
    begin
      paddr_tv_r    <= {ptag_i, vaddr_tl_r};
      hit_tv_r      <= hit_way_tl;
      way_data_tv_r <= way_data_tl;
    end
  end

  ////////////////////
  // Tag verify
  ////////////////////
  // Hit vector is one-hot, so OR the selected ways together
  always_comb
  begin
    hit_idx_tv = '0;
    block_tv   = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (hit_tv_r[w])
      begin
        hit_idx_tv = way_width_lp'(w);
        block_tv   = block_tv | way_data_tv_r[w];
      end
    end
  end

  assign word_sel_tv = paddr_tv_r[2 +: word_sel_width_lp];
  assign data_o      = block_tv[word_sel_tv*`ICACHE_INSTR_WIDTH +: `ICACHE_INSTR_WIDTH];
  assign data_v_o    = v_tv_r & (|hit_tv_r);
  assign miss_v_o    = v_tv_r & ~(|hit_tv_r);

  // paddr_tv_r holds the missing fetch until the next accepted fetch
  icache_lru lru_i
    (.clk_i(clk_i), .reset_i(reset_i), .hit_v_i(data_v_o), .hit_way_i(hit_idx_tv)
     , .index_i(paddr_tv_r[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH])
     , .req_yumi_i(cache_req_yumi_i), .metadata_v_o(cache_req_metadata_v_o)
     , .metadata_way_o(cache_req_metadata_way_o));

  icache_miss_ctrl miss_ctrl_i
    (.clk_i(clk_i), .reset_i(reset_i), .miss_i(miss_v_o), .miss_addr_i(paddr_tv_r)
     , .req_yumi_i(cache_req_yumi_i), .complete_i(cache_req_complete_i)
     , .ready_o(ready_o), .req_v_o(cache_req_v_o), .req_addr_o(cache_req_addr_o));

endmodule

/* icache_tb.sv */
// Testbench for the instruction cache, engine model, reference model, compare tasks and timeout
`timescale 1ns/1ns
`include "icache_config.svh"

module icache_tb;

  localparam int way_width_lp = $clog2(`ICACHE_WAYS);
  localparam int words_lp     = `ICACHE_BLOCK_WIDTH / `ICACHE_INSTR_WIDTH;

  logic                               clk_i;
  logic                               reset_i;
  logic                               fetch_v_i;
  logic [`ICACHE_VADDR_WIDTH-1:0]     fetch_vaddr_i;
  logic                               ready_o;
  logic [`ICACHE_PTAG_WIDTH-1:0]      ptag_i;
  logic                               ptag_v_i;
  logic [`ICACHE_INSTR_WIDTH-1:0]     data_o;
  logic                               data_v_o;
  logic                               miss_v_o;
  logic                               cache_req_v_o;
  logic [`ICACHE_PADDR_WIDTH-1:0]     cache_req_addr_o;
  logic                               cache_req_yumi_i;
  logic                               cache_req_metadata_v_o;
  logic [way_width_lp-1:0]            cache_req_metadata_way_o;
  logic                               cache_req_complete_i;
  logic                               tag_pkt_v_i;
  icache_pkg::icache_tag_op_e         tag_pkt_op_i;
  logic [`ICACHE_INDEX_WIDTH-1:0]     tag_pkt_index_i;
  logic [way_width_lp-1:0]            tag_pkt_way_i;
  logic [`ICACHE_PTAG_WIDTH-1:0]      tag_pkt_tag_i;
  logic                               tag_pkt_yumi_o;
  logic                               data_pkt_v_i;
  logic [`ICACHE_INDEX_WIDTH-1:0]     data_pkt_index_i;
  logic [way_width_lp-1:0]            data_pkt_way_i;
  logic [`ICACHE_BLOCK_WIDTH-1:0]     data_pkt_data_i;
  logic                               data_pkt_yumi_o;

  // Cache model, tags and valids follow the fills, LRU follows the hits
  logic [`ICACHE_PTAG_WIDTH-1:0] model_tag   [`ICACHE_WAYS][`ICACHE_SETS];
  logic                          model_valid [`ICACHE_WAYS][`ICACHE_SETS];
  logic [way_width_lp-1:0]       model_lru   [`ICACHE_SETS];

  logic [15:0] lfsr_q      = 16'd51;
  int          issued      = 0;
  logic        reset_done  = 1'b0;
  logic        clear_done  = 1'b0;
  logic        engine_busy = 1'b0;

  icache_top icache_top_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic word_check(input string name, input logic [`ICACHE_INSTR_WIDTH-1:0] got,
                            input logic [`ICACHE_INSTR_WIDTH-1:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("error at %0t ns: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic flag_check(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_failure($sformatf("error at %0t ns: %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic addr_check(input string name, input logic [`ICACHE_PADDR_WIDTH-1:0] got,
                            input logic [`ICACHE_PADDR_WIDTH-1:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("error at %0t ns: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic way_check(input string name, input logic [way_width_lp-1:0] got,
                           input logic [way_width_lp-1:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
  endtask

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++)
    begin
      r = (r << 1) | int'(lfsr_q[15]);
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    end
    return r;
  endfunction

  // Memory word at a word address, a fixed mix of its bits
  function automatic logic [`ICACHE_INSTR_WIDTH-1:0] ref_word(
    input logic [`ICACHE_PADDR_WIDTH-1:0] paddr);
    logic [31:0] w;
    w = {2'b00, paddr[31:2]};
    return w ^ (w << 13) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [`ICACHE_BLOCK_WIDTH-1:0] fill_block(
    input logic [`ICACHE_PADDR_WIDTH-1:0] paddr);
    logic [`ICACHE_BLOCK_WIDTH-1:0] blk;
    for (int i = 0; i < words_lp; i++)
      blk[i*`ICACHE_INSTR_WIDTH +: `ICACHE_INSTR_WIDTH] =
        ref_word({paddr[`ICACHE_PADDR_WIDTH-1:`ICACHE_OFFSET_WIDTH], 2'(i), 2'b00});
    return blk;
  endfunction

  function automatic int set_of(input logic [`ICACHE_PADDR_WIDTH-1:0] paddr);
    return int'(paddr[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH]);
  endfunction

  function automatic logic [`ICACHE_PTAG_WIDTH-1:0] tag_of(
    input logic [`ICACHE_PADDR_WIDTH-1:0] paddr);
    return paddr[`ICACHE_PADDR_WIDTH-1 -: `ICACHE_PTAG_WIDTH];
  endfunction

  // Four tags to pick from
  function automatic logic [`ICACHE_PADDR_WIDTH-1:0] fetch_addr(input int tag_sel,
                                                                input int index, input int word);
    logic [`ICACHE_PTAG_WIDTH-1:0] tag;
    case (tag_sel)
      0:       tag = 20'h12340;
      1:       tag = 20'h56781;
      2:       tag = 20'h9abc2;
      default: tag = 20'hdef03;
    endcase
    return {tag, `ICACHE_INDEX_WIDTH'(index), 2'(word), 2'b00};
  endfunction

  // Way holding the block, or -1 for a miss
  function automatic int predict_way(input logic [`ICACHE_PADDR_WIDTH-1:0] paddr);
    int way;
    way = -1;
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (model_valid[w][set_of(paddr)] && (model_tag[w][set_of(paddr)] == tag_of(paddr)))
        way = w;
    return way;
  endfunction

  // Identity translation, the physical tag is the upper virtual address
  task automatic issue_fetch(input logic [`ICACHE_VADDR_WIDTH-1:0] vaddr, input logic pv);
    fetch_v_i     = 1'b1;
    fetch_vaddr_i = vaddr;
    issued        = issued + 1;
    @(posedge clk_i);
    while (!ready_o)
      @(posedge clk_i);
    @(negedge clk_i);
    fetch_v_i = 1'b0;
    ptag_i    = vaddr[`ICACHE_VADDR_WIDTH-1 -: `ICACHE_PTAG_WIDTH];
    ptag_v_i  = pv;
  endtask

  ////////////////////
  // Engine model
  ////////////////////

  task automatic clear_sets();
    for (int s = 0; s < `ICACHE_SETS; s++)
    begin
      @(negedge clk_i);
      tag_pkt_v_i     = 1'b1;
      tag_pkt_op_i    = icache_pkg::e_tag_clear;
      tag_pkt_index_i = `ICACHE_INDEX_WIDTH'(s);
      @(posedge clk_i);
      flag_check("tag_pkt_yumi_o", tag_pkt_yumi_o, 1'b1);
      for (int w = 0; w < `ICACHE_WAYS; w++)
        model_valid[w][s] = 1'b0;
    end
    @(negedge clk_i);
    tag_pkt_v_i = 1'b0;
  endtask

  task automatic serve_miss();
    logic [`ICACHE_PADDR_WIDTH-1:0] paddr;
    logic [way_width_lp-1:0]        victim;
    int                             delay;
    engine_busy = 1'b1;
    paddr       = cache_req_addr_o;
    victim      = ~model_lru[set_of(paddr)];
    delay       = rand_bits(3);
    flag_check("ready_o", ready_o, 1'b0);
    // Back-pressure, request holds still
    repeat (delay)
    begin
      @(posedge clk_i);
      flag_check("cache_req_v_o", cache_req_v_o, 1'b1);
      addr_check("cache_req_addr_o", cache_req_addr_o, paddr);
      flag_check("ready_o", ready_o, 1'b0);
    end
    @(negedge clk_i);
    cache_req_yumi_i = 1'b1;
    @(posedge clk_i);
    flag_check("cache_req_v_o", cache_req_v_o, 1'b1);
    addr_check("cache_req_addr_o", cache_req_addr_o, paddr);
    @(negedge clk_i);
    cache_req_yumi_i = 1'b0;
    @(posedge clk_i);
    flag_check("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b1);
    way_check("cache_req_metadata_way_o", cache_req_metadata_way_o, victim);
    flag_check("cache_req_v_o", cache_req_v_o, 1'b0);
    // Block first, then the tag
    @(negedge clk_i);
    data_pkt_v_i     = 1'b1;
    data_pkt_index_i = `ICACHE_INDEX_WIDTH'(set_of(paddr));
    data_pkt_way_i   = victim;
    data_pkt_data_i  = fill_block(paddr);
    @(posedge clk_i);
    flag_check("data_pkt_yumi_o", data_pkt_yumi_o, 1'b1);
    flag_check("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b0);
    @(negedge clk_i);
    data_pkt_v_i    = 1'b0;
    tag_pkt_v_i     = 1'b1;
    tag_pkt_op_i    = icache_pkg::e_tag_set;
    tag_pkt_index_i = `ICACHE_INDEX_WIDTH'(set_of(paddr));
    tag_pkt_way_i   = victim;
    tag_pkt_tag_i   = tag_of(paddr);
    @(posedge clk_i);
    flag_check("tag_pkt_yumi_o", tag_pkt_yumi_o, 1'b1);
    @(negedge clk_i);
    tag_pkt_v_i          = 1'b0;
    cache_req_complete_i = 1'b1;
    model_tag[victim][set_of(paddr)]   = tag_of(paddr);
    model_valid[victim][set_of(paddr)] = 1'b1;
    @(posedge clk_i);
    flag_check("ready_o", ready_o, 1'b0);
    @(negedge clk_i);
    cache_req_complete_i = 1'b0;
    @(posedge clk_i);
    flag_check("ready_o", ready_o, 1'b1);
    engine_busy = 1'b0;
  endtask

  initial
  begin : engine
    cache_req_yumi_i     = 1'b0;
    cache_req_complete_i = 1'b0;
    tag_pkt_v_i          = 1'b0;
    tag_pkt_op_i         = icache_pkg::e_tag_set;
    tag_pkt_index_i      = '0;
    tag_pkt_way_i        = '0;
    tag_pkt_tag_i        = '0;
    data_pkt_v_i         = 1'b0;
    data_pkt_index_i     = '0;
    data_pkt_way_i       = '0;
    data_pkt_data_i      = '0;
    for (int s = 0; s < `ICACHE_SETS; s++)
      model_lru[s] = '0;
    wait (reset_done);
    clear_sets();
    clear_done = 1'b1;
    forever
    begin
      @(posedge clk_i);
      if (cache_req_v_o)
        serve_miss();
    end
  end

  ////////////////////
  // Compare
  ////////////////////

  initial
  begin : compare
    logic                           tl_v;
    logic [`ICACHE_VADDR_WIDTH-1:0] tl_addr;
    logic                           tv_v;
    logic [`ICACHE_PADDR_WIDTH-1:0] tv_addr;
    logic                           tv_miss;
    int                             way;
    tl_v    = 1'b0;
    tl_addr = '0;
    tv_v    = 1'b0;
    tv_addr = '0;
    wait (reset_done);
    forever
    begin
      @(posedge clk_i);
      tv_miss = 1'b0;
      if (tv_v)
      begin
        way     = predict_way(tv_addr);
        tv_miss = (way < 0);
        flag_check("data_v_o", data_v_o, !tv_miss);
        flag_check("miss_v_o", miss_v_o, tv_miss);
        if (tv_miss)
        begin
          flag_check("cache_req_v_o", cache_req_v_o, 1'b1);
          addr_check("cache_req_addr_o", cache_req_addr_o, tv_addr);
        end
        else
        begin
          word_check("data_o", data_o, ref_word(tv_addr));
          model_lru[set_of(tv_addr)] = way_width_lp'(way);
        end
      end
      else
      begin
        flag_check("data_v_o", data_v_o, 1'b0);
        flag_check("miss_v_o", miss_v_o, 1'b0);
      end
      // Dropped ptag and miss squash both empty tag verify
      tv_v    = tl_v & ptag_v_i & ~tv_miss;
      tv_addr = {ptag_i, tl_addr[`ICACHE_PAGE_OFFSET_WIDTH-1:0]};
      tl_v    = ready_o & fetch_v_i;
      tl_addr = fetch_vaddr_i;
    end
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    forever
    begin
      @(posedge clk_i);
      cycles = cycles + 1;
      if (cycles > 40 * issued + 600)
        stop_with_failure($sformatf("timeout, the run stalled after %0d cycles", cycles));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial
  begin : stimulus
    int   t;
    int   ix;
    int   wd;
    logic pv;
    reset_i       = 1'b1;
    fetch_v_i     = 1'b0;
    fetch_vaddr_i = '0;
    ptag_i        = '0;
    ptag_v_i      = 1'b0;
    // No fetch is taken while reset is held
    repeat (8)
    begin
      @(posedge clk_i);
      flag_check("ready_o", ready_o, 1'b0);
    end
    @(negedge clk_i);
    reset_i    = 1'b0;
    reset_done = 1'b1;
    @(posedge clk_i);
    flag_check("ready_o", ready_o, 1'b1);
    flag_check("cache_req_v_o", cache_req_v_o, 1'b0);
    flag_check("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b0);
    wait (clear_done);
    @(negedge clk_i);

    // Cold miss then the same word from the fill
    issue_fetch(fetch_addr(0, 5, 1), 1'b1);
    issue_fetch(fetch_addr(0, 5, 1), 1'b1);
    // Whole block back to back
    for (int w = 0; w < words_lp; w++)
      issue_fetch(fetch_addr(0, 5, w), 1'b1);
    // Three tags through one set
    issue_fetch(fetch_addr(1, 5, 2), 1'b1);
    issue_fetch(fetch_addr(1, 5, 2), 1'b1);
    issue_fetch(fetch_addr(2, 5, 0), 1'b1);
    issue_fetch(fetch_addr(1, 5, 1), 1'b1);
    issue_fetch(fetch_addr(0, 5, 3), 1'b1);
    issue_fetch(fetch_addr(2, 5, 0), 1'b1);
    // No physical tag, fetch dropped
    issue_fetch(fetch_addr(1, 5, 0), 1'b0);
    issue_fetch(fetch_addr(1, 5, 3), 1'b1);
    // The fetch behind a miss is squashed
    issue_fetch(fetch_addr(3, 5, 0), 1'b1);
    issue_fetch(fetch_addr(1, 5, 1), 1'b1);
    issue_fetch(fetch_addr(1, 5, 1), 1'b1);

    // Random mix over four tags and four sets
    for (int n = 0; n < 60; n++)
    begin
      t  = rand_bits(2);
      ix = 16 + rand_bits(2);
      wd = rand_bits(2);
      pv = (rand_bits(3) != 0);
      issue_fetch(fetch_addr(t, ix, wd), pv);
    end

    repeat (3) @(posedge clk_i);
    while (engine_busy || !ready_o)
      @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+.
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_lru.sv
icache_miss_ctrl.sv
icache_top.sv
icache_tb.sv

/* Makefile */
# Verilator lint and simulation of the instruction cache testbench

TOP := icache_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

# Pass only when the log holds the pass line
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
